// File: design/ialu_pkg.sv
// --------------------------------------
// Integer ALU shared definitions
// Command codes, subtract flags, multiply
// sequencer states and the default width
// --------------------------------------

package ialu_pkg;

    // Default data width, top level may override
    parameter int ialu_xlen_default = 32;

    // --------------------------------------
    // ALU command codes
    // --------------------------------------
    typedef enum logic [4:0] {
        IALU_CMD_ADD,       // op1 + op2
        IALU_CMD_SUB,       // op1 - op2
        IALU_CMD_AND,
        IALU_CMD_OR,
        IALU_CMD_XOR,
        IALU_CMD_SUB_LT,    // Signed less than
        IALU_CMD_SUB_LTU,   // Unsigned less than
        IALU_CMD_SUB_EQ,
        IALU_CMD_SUB_NE,
        IALU_CMD_SUB_GE,    // Signed greater or equal
        IALU_CMD_SUB_GEU,   // Unsigned greater or equal
        IALU_CMD_SLL,
        IALU_CMD_SRL,
        IALU_CMD_SRA,
        IALU_CMD_MUL,       // Low half
        IALU_CMD_MULH,      // High half, signed x signed
        IALU_CMD_MULHSU,    // High half, signed x unsigned
        IALU_CMD_MULHU      // High half, unsigned x unsigned
    } ialu_cmd_e;

    // Flags of the main subtraction
    typedef struct packed {
        logic z;    // Zero
        logic s;    // Sign
        logic o;    // Signed overflow
        logic c;    // Borrow out
    } ialu_flags_s;

    // Multiply sequencer state
    typedef enum logic {
        MDU_IDLE,   // Waiting, load cycle
        MDU_ITER    // Iterating over op2 bits
    } mdu_state_e;

endpackage : ialu_pkg

// File: design/ialu_mdu_if.sv
// --------------------------------------
// Sequencer to multiplier link
// Iteration control one way, running
// product halves back
// --------------------------------------

interface ialu_mdu_if #(
    parameter int XLEN = ialu_pkg::ialu_xlen_default
);

    logic            load;          // First multiply cycle
    logic            step;          // Later iteration
    logic            op1_signed;    // op1 read as signed
    logic            op2_signed;    // op2 read as signed
    logic            last;          // Final iteration, op2 MSB weight
    logic [XLEN-1:0] prod_hi;       // Product high half, next value
    logic [XLEN-1:0] prod_lo;       // Product low half, next value

    // Sequencer side
    modport ctrl (
        output load, step, op1_signed, op2_signed, last,
        input  prod_hi, prod_lo
    );

    // Datapath side
    modport dp (
        input  load, step, op1_signed, op2_signed, last,
        output prod_hi, prod_lo
    );

endinterface : ialu_mdu_if

// File: design/ialu_int_unit.sv
// --------------------------------------
// Single-cycle integer unit
// Main adder with flags, branch compares,
// bitwise logic and barrel shifter
// --------------------------------------

module ialu_int_unit #(
    parameter int XLEN = ialu_pkg::ialu_xlen_default
) (
    input  ialu_pkg::ialu_cmd_e cmd_i,
    input  logic [XLEN-1:0]     op1_i,
    input  logic [XLEN-1:0]     op2_i,
    output logic [XLEN-1:0]     int_res_o,
    output logic                int_cmp_o
);

    import ialu_pkg::*;

    localparam int SHW = $clog2(XLEN);      // Shift amount width

    logic [XLEN:0]          sum;            // Adder result plus carry
    ialu_flags_s            flags;
    logic                   lt_s;           // Signed less than
    logic signed [XLEN-1:0] shft_src;
    logic [SHW-1:0]         shamt;

    // --------------------------------------
    // Main adder
    // --------------------------------------
    // Subtracts for everything but ADD, so compares share it
    always_comb begin
        if (cmd_i != IALU_CMD_ADD) begin
            sum = {1'b0, op1_i} - {1'b0, op2_i};
        end else begin
            sum = {1'b0, op1_i} + {1'b0, op2_i};
        end

        flags.c = sum[XLEN];                // Borrow means op1 < op2 unsigned
        flags.z = ~|sum[XLEN-1:0];
        flags.s = sum[XLEN-1];
        // Operand signs differ and result sign flipped
        flags.o = (op1_i[XLEN-1] ^ op2_i[XLEN-1]) & (op1_i[XLEN-1] ^ sum[XLEN-1]);
    end

    assign lt_s = flags.s ^ flags.o;

    // Shifter operands
    assign shft_src = op1_i;                // Signed view for SRA
    assign shamt    = op2_i[SHW-1:0];

    // --------------------------------------
    // Result select
    // --------------------------------------
    always_comb begin
        int_res_o = '0;                     // Multiply commands stay 0
        int_cmp_o = 1'b0;

        case (cmd_i)
            IALU_CMD_ADD,
            IALU_CMD_SUB:     int_res_o = sum[XLEN-1:0];
            IALU_CMD_AND:     int_res_o = op1_i & op2_i;
            IALU_CMD_OR:      int_res_o = op1_i | op2_i;
            IALU_CMD_XOR:     int_res_o = op1_i ^ op2_i;
            IALU_CMD_SUB_LT:  int_cmp_o = lt_s;
            IALU_CMD_SUB_LTU: int_cmp_o = flags.c;
            IALU_CMD_SUB_EQ:  int_cmp_o = flags.z;
            IALU_CMD_SUB_NE:  int_cmp_o = ~flags.z;
            IALU_CMD_SUB_GE:  int_cmp_o = ~lt_s;
            IALU_CMD_SUB_GEU: int_cmp_o = ~flags.c;
            IALU_CMD_SLL:     int_res_o = op1_i << shamt;
            IALU_CMD_SRL:     int_res_o = op1_i >> shamt;
            IALU_CMD_SRA:     int_res_o = shft_src >>> shamt;   // Sign fill
            default: begin
            end
        endcase

        // Compare outcome also as a zero-extended word
        if (int_cmp_o) begin
            int_res_o = XLEN'(1'b1);
        end
    end

endmodule : ialu_int_unit

// File: design/ialu_mul_iter.sv
// --------------------------------------
// Radix-2 iterative multiplier datapath
// One op2 bit per cycle, partial product
// added into high half, low half shifts
// --------------------------------------

module ialu_mul_iter #(
    parameter int XLEN = ialu_pkg::ialu_xlen_default
) (
    input  logic            clk,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    ialu_mdu_if.dp          mdu
);

    logic [XLEN-1:0] hi_q;          // Running high half
    logic [XLEN-1:0] lo_q;          // Low half, remaining op2 bits above

    logic [XLEN:0]   mcand;         // op1 with sign or zero bit on top
    logic [XLEN-1:0] lo_src;        // Where op2 bits come from
    logic            mbit;          // Current multiplier bit
    logic            mbit_neg;      // Bit carries negative weight
    logic [XLEN:0]   acc;           // Extended high half
    logic [XLEN:0]   pp;            // Partial product
    logic [XLEN:0]   sum;

    // --------------------------------------
    // Operand forming
    // --------------------------------------
    assign mcand = {mdu.op1_signed & op1_i[XLEN-1], op1_i};

    // Port on load, low register afterwards
    assign lo_src = mdu.load ? op2_i : lo_q;
    assign mbit   = lo_src[0];

    // Signed op2 MSB counts as -2^(XLEN-1)
    assign mbit_neg = mdu.last & mdu.op2_signed & mbit;

    // Accumulator starts from zero on load
    always_comb begin
        if (mdu.load) begin
            acc = '0;
        end else begin
            acc = {mdu.op1_signed & hi_q[XLEN-1], hi_q};
        end
    end

    // Partial product is 0, +mcand or -mcand
    always_comb begin
        if (!mbit) begin
            pp = '0;
        end else if (mbit_neg) begin
            pp = -mcand;
        end else begin
            pp = mcand;
        end
    end

    assign sum = acc + pp;          // Wraps in XLEN+1 bits

    // --------------------------------------
    // Next product and registers
    // --------------------------------------
    // Sum LSB drops into the top of the low half
    assign mdu.prod_hi = sum[XLEN:1];
    assign mdu.prod_lo = {sum[0], lo_src[XLEN-1:1]};

    always_ff @(posedge clk) begin
        if (mdu.load || mdu.step) begin
            hi_q <= mdu.prod_hi;
            lo_q <= mdu.prod_lo;
        end
    end

endmodule : ialu_mul_iter

// File: design/ialu_ctrl.sv
// --------------------------------------
// ALU control
// Multiply decode, IDLE/ITER sequencer,
// iteration counter, ready and result
// select
// --------------------------------------

module ialu_ctrl #(
    parameter int XLEN = ialu_pkg::ialu_xlen_default
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid_i,
    input  ialu_pkg::ialu_cmd_e cmd_i,
    input  logic [XLEN-1:0]     op1_i,
    input  logic [XLEN-1:0]     op2_i,
    input  logic [XLEN-1:0]     int_res_i,
    input  logic                int_cmp_i,
    ialu_mdu_if.ctrl            mdu,
    output logic [XLEN-1:0]     result_o,
    output logic                cmp_o,
    output logic                res_ready_o
);

    import ialu_pkg::*;

    localparam int CNT_W = $clog2(XLEN);    // Holds XLEN-2

    mdu_state_e       state_q;
    mdu_state_e       state_next;
    logic [CNT_W-1:0] iter_cnt_q;           // Iterations left after this one
    logic             cnt_zero;

    logic             is_mul;
    logic             mul_hi;               // High half wanted
    logic             ops_non_zero;
    logic             mdu_load;
    logic             mdu_step;

    // --------------------------------------
    // Command decode
    // --------------------------------------
    assign is_mul = (cmd_i == IALU_CMD_MUL) | (cmd_i == IALU_CMD_MULH)
                  | (cmd_i == IALU_CMD_MULHSU) | (cmd_i == IALU_CMD_MULHU);
    assign mul_hi = (cmd_i == IALU_CMD_MULH) | (cmd_i == IALU_CMD_MULHSU)
                  | (cmd_i == IALU_CMD_MULHU);

    // MULHU alone reads op1 unsigned
    assign mdu.op1_signed = (cmd_i == IALU_CMD_MUL) | (cmd_i == IALU_CMD_MULH)
                          | (cmd_i == IALU_CMD_MULHSU);
    assign mdu.op2_signed = (cmd_i == IALU_CMD_MUL) | (cmd_i == IALU_CMD_MULH);

    assign ops_non_zero = (|op1_i) & (|op2_i);  // Zero operand skips iterating

    // Iteration control
    assign cnt_zero = (iter_cnt_q == '0);
    assign mdu_load = cmd_valid_i & is_mul & ops_non_zero & (state_q == MDU_IDLE);
    assign mdu_step = cmd_valid_i & is_mul & (state_q == MDU_ITER);

    assign mdu.load = mdu_load;
    assign mdu.step = mdu_step;
    assign mdu.last = (state_q == MDU_ITER) & cnt_zero;

    // --------------------------------------
    // Sequencer
    // --------------------------------------
    always_comb begin
        state_next = MDU_IDLE;              // Dropped valid aborts
        if (cmd_valid_i) begin
            case (state_q)
                MDU_IDLE: state_next = mdu_load ? MDU_ITER : MDU_IDLE;
                MDU_ITER: state_next = cnt_zero ? MDU_IDLE : MDU_ITER;
                default:  state_next = MDU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= MDU_IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    // Down counter, ready in cycle XLEN
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iter_cnt_q <= '0;
        end else if (mdu_load) begin
            iter_cnt_q <= CNT_W'(XLEN - 2);
        end else if (mdu_step && !cnt_zero) begin
            iter_cnt_q <= iter_cnt_q - 1'b1;
        end
    end

    // --------------------------------------
    // Result select and ready
    // --------------------------------------
    always_comb begin
        result_o    = int_res_i;
        cmp_o       = int_cmp_i;
        res_ready_o = cmd_valid_i;          // Single-cycle by default

        if (is_mul) begin
            cmp_o = 1'b0;
            case (state_q)
                MDU_ITER: begin
                    result_o    = mul_hi ? mdu.prod_hi : mdu.prod_lo;
                    res_ready_o = cmd_valid_i & cnt_zero;
                end
                default: begin
                    result_o    = '0;       // Zero operand gives 0 at once
                    res_ready_o = cmd_valid_i & ~ops_non_zero;
                end
            endcase
        end
    end

endmodule : ialu_ctrl

// File: design/ialu.sv
// --------------------------------------
// Integer ALU top level
// Int unit, iterative multiplier and
// control with a valid/ready command port
// --------------------------------------

module ialu #(
    parameter int XLEN = ialu_pkg::ialu_xlen_default
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid_i,    // Command held until ready
    input  ialu_pkg::ialu_cmd_e cmd_i,
    input  logic [XLEN-1:0]     op1_i,
    input  logic [XLEN-1:0]     op2_i,
    output logic [XLEN-1:0]     result_o,       // Valid with ready
    output logic                cmp_o,
    output logic                res_ready_o
);

    logic [XLEN-1:0] int_res;
    logic            int_cmp;

    ialu_mdu_if #(.XLEN(XLEN)) mdu_if ();

    // Single-cycle path
    ialu_int_unit #(.XLEN(XLEN)) u_int_unit (
        .cmd_i     (cmd_i),
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .int_res_o (int_res),
        .int_cmp_o (int_cmp)
    );

    // Multiplier datapath
    ialu_mul_iter #(.XLEN(XLEN)) u_mul_iter (
        .clk   (clk),
        .op1_i (op1_i),
        .op2_i (op2_i),
        .mdu   (mdu_if.dp)
    );

    ialu_ctrl #(.XLEN(XLEN)) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .int_res_i   (int_res),
        .int_cmp_i   (int_cmp),
        .mdu         (mdu_if.ctrl),
        .result_o    (result_o),
        .cmp_o       (cmp_o),
        .res_ready_o (res_ready_o)
    );

endmodule : ialu

// File: dv/ialu_props.sv
// --------------------------------------
// Sequencer assertions for the ALU
// Bound into the control block
// --------------------------------------

module ialu_props #(
    parameter int XLEN = ialu_pkg::ialu_xlen_default
) (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       cmd_valid_i,
    input logic                       res_ready_o,
    input logic                       is_mul,
    input logic                       mdu_load,
    input ialu_pkg::mdu_state_e       state_q,
    input logic [$clog2(XLEN)-1:0]    iter_cnt_q
);
    timeunit 1ns;
    timeprecision 1ps;

    import ialu_pkg::*;

    // Ready never without valid
    a_ready_valid: assert property (@(posedge clk) disable iff (!rst_n)
        res_ready_o |-> cmd_valid_i)
        else $error("res_ready_o high while cmd_valid_i low");

    // ITER holds until counter empty
    a_iter_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_valid_i && state_q == MDU_ITER && iter_cnt_q != '0) |=> state_q == MDU_ITER)
        else $error("Sequencer left ITER with iterations left");

    // Back in IDLE after multiply result
    a_idle_after: assert property (@(posedge clk) disable iff (!rst_n)
        (is_mul && res_ready_o) |=> state_q == MDU_IDLE)
        else $error("Sequencer not IDLE after multiply ready");

    a_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
        mdu_load |-> state_q == MDU_IDLE)
        else $error("Multiplier load outside IDLE");   // Load only starts a multiply

endmodule : ialu_props

bind ialu_ctrl ialu_props #(.XLEN(XLEN)) u_props (
    .clk(clk), .rst_n(rst_n), .cmd_valid_i(cmd_valid_i), .res_ready_o(res_ready_o),
    .is_mul(is_mul), .mdu_load(mdu_load), .state_q(state_q), .iter_cnt_q(iter_cnt_q)
);

// File: dv/ialu_tb.sv
// --------------------------------------
// Integer ALU testbench
// Directed tests on all commands with a
// reference model and latency checks
// --------------------------------------

module ialu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ialu_pkg::*;

    localparam int TIMEOUT = 100;           // Cycles per request

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    ialu_cmd_e   cmd;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] result;
    logic        cmp;
    logic        res_ready;
    integer      seed = 46;
    int          checks, errors, test_checks, test_errors;
    logic [31:0] edges [5] = '{32'h0, 32'h1, 32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF};

    ialu #(.XLEN(32)) dut0 (
        .clk(clk), .rst_n(rst_n), .cmd_valid_i(cmd_valid), .cmd_i(cmd),
        .op1_i(op1), .op2_i(op2), .result_o(result), .cmp_o(cmp),
        .res_ready_o(res_ready)
    );

    always #5 clk = ~clk;

    // --------------------------------------
    // Reference model
    // --------------------------------------
    function automatic logic [63:0] mul_model(ialu_cmd_e c, logic [31:0] a, logic [31:0] b);
        logic [63:0] a64, b64;
        a64 = (c != IALU_CMD_MULHU) ? {{32{a[31]}}, a} : {32'h0, a};   // Signed unless MULHU
        b64 = (c == IALU_CMD_MUL || c == IALU_CMD_MULH) ? {{32{b[31]}}, b} : {32'h0, b};
        return a64 * b64;
    endfunction

    // Returns {cmp, result}
    function automatic logic [32:0] alu_model(ialu_cmd_e c, logic [31:0] a, logic [31:0] b);
        logic        k;
        logic [31:0] r;
        k = 1'b0;
        r = 32'h0;
        case (c)
            IALU_CMD_ADD:     r = a + b;
            IALU_CMD_SUB:     r = a - b;
            IALU_CMD_AND:     r = a & b;
            IALU_CMD_OR:      r = a | b;
            IALU_CMD_XOR:     r = a ^ b;
            IALU_CMD_SUB_LT:  k = $signed(a) < $signed(b);
            IALU_CMD_SUB_LTU: k = a < b;
            IALU_CMD_SUB_EQ:  k = a == b;
            IALU_CMD_SUB_NE:  k = a != b;
            IALU_CMD_SUB_GE:  k = $signed(a) >= $signed(b);
            IALU_CMD_SUB_GEU: k = a >= b;
            IALU_CMD_SLL:     r = a << b[4:0];
            IALU_CMD_SRL:     r = a >> b[4:0];
            IALU_CMD_SRA:     r = $unsigned($signed(a) >>> b[4:0]);
            IALU_CMD_MUL:     r = mul_model(c, a, b) >> 0;
            default:          r = mul_model(c, a, b) >> 32;    // High half variants
        endcase
        if (k) begin
            r = 32'h1;                      // Compare result zero-extended
        end
        return {k, r};
    endfunction

    // Latency in cycles counted from the first valid cycle
    function automatic int exp_latency(ialu_cmd_e c, logic [31:0] a, logic [31:0] b);
        if (c >= IALU_CMD_MUL && a != 0 && b != 0) return 32;
        return 1;
    endfunction

    // --------------------------------------
    // Request and check helpers
    // --------------------------------------
    task automatic flag_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
        $display("FAIL %s %s op1=%h op2=%h: got %h expected %h",
                 cmd.name(), sig, op1, op2, got, exp);
        errors++;
        test_errors++;
    endtask

    // Drive a command and wait for ready, leaves valid high
    task automatic send(ialu_cmd_e c, logic [31:0] a, logic [31:0] b,
                        output logic [31:0] r, output logic k, output int n);
        logic seen;
        seen = 1'b0;
        n = 0;
        r = 32'h0;
        k = 1'b0;
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd = c;
        op1 = a;
        op2 = b;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);                 // Outputs settled mid cycle
            n++;
            if (res_ready) begin
                seen = 1'b1;
                r = result;
                k = cmp;
            end
        end
        if (!seen) begin
            $display("ERROR: %s got no res_ready_o within %0d cycles", c.name(), TIMEOUT);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_cmd(ialu_cmd_e c, logic [31:0] a, logic [31:0] b);
        logic [31:0] r;
        logic        k;
        int          n;
        logic [32:0] exp;
        send(c, a, b, r, k, n);
        exp = alu_model(c, a, b);
        checks++;
        test_checks++;
        assert (r === exp[31:0]) else flag_mismatch("result_o", r, exp[31:0]);
        assert (k === exp[32]) else flag_mismatch("cmp_o", 32'(k), 32'(exp[32]));
        assert (n == exp_latency(c, a, b))
            else flag_mismatch("res_ready_o cycle", n, exp_latency(c, a, b));
    endtask

    task automatic release_bus();
        @(posedge clk);
        #1 cmd_valid = 1'b0;
    endtask

    task automatic finish_test(string name);
        $display("test %-12s %0d commands, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // --------------------------------------
    // Directed tests
    // --------------------------------------
    task automatic test_idle_b2b();
        repeat (4) begin
            @(negedge clk);
            test_checks++;
            assert (res_ready === 1'b0) else flag_mismatch("res_ready_o idle", res_ready, 0);
        end
        check_cmd(IALU_CMD_MULHU, $random(seed), $random(seed));
        check_cmd(IALU_CMD_MUL, $random(seed), $random(seed));   // Cycle after ready
        release_bus();
        finish_test("idle_b2b");
    endtask

    // Edge pairs and random pairs over a command range
    task automatic test_range(string name, ialu_cmd_e first, ialu_cmd_e last, int n_rand);
        for (int i = int'(first); i <= int'(last); i++) begin
            foreach (edges[a]) begin
                foreach (edges[b]) begin
                    check_cmd(ialu_cmd_e'(i), edges[a], edges[b]);
                end
            end
            repeat (n_rand) check_cmd(ialu_cmd_e'(i), $random(seed), $random(seed));
        end
        release_bus();
        finish_test(name);
    endtask

    task automatic test_shift();
        logic [31:0] amts [4];
        for (int i = int'(IALU_CMD_SLL); i <= int'(IALU_CMD_SRA); i++) begin
            amts = '{32'd0, 32'd1, 32'd31, $random(seed)};
            foreach (amts[j]) begin
                check_cmd(ialu_cmd_e'(i), 32'h8000_0001, amts[j]);
                check_cmd(ialu_cmd_e'(i), $random(seed), amts[j]);
            end
        end
        release_bus();
        finish_test("shift");
    endtask

    task automatic test_mul_zero();
        for (int i = int'(IALU_CMD_MUL); i <= int'(IALU_CMD_MULHU); i++) begin
            check_cmd(ialu_cmd_e'(i), 32'h0, $random(seed));
            check_cmd(ialu_cmd_e'(i), $random(seed), 32'h0);
        end
        release_bus();
        finish_test("mul_zero");
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd = IALU_CMD_ADD;
        op1 = 32'h0;
        op2 = 32'h0;
        checks = 0;
        errors = 0;
        test_checks = 0;
        test_errors = 0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        test_idle_b2b();
        test_range("arith_logic", IALU_CMD_ADD, IALU_CMD_XOR, 20);
        test_range("compare", IALU_CMD_SUB_LT, IALU_CMD_SUB_GEU, 10);
        test_shift();
        test_range("multiply", IALU_CMD_MUL, IALU_CMD_MULHU, 8);
        test_mul_zero();

        $display("Total: %0d commands checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : ialu_tb

// File: sim.f
design/ialu_pkg.sv
design/ialu_mdu_if.sv
design/ialu_int_unit.sv
design/ialu_mul_iter.sv
design/ialu_ctrl.sv
design/ialu.sv
dv/ialu_props.sv
dv/ialu_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the integer ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module ialu_tb -o ialu_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/ialu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
else
    exit 1
fi
